// ==== rgmii_mac.f ====
+incdir+.
eth_frame_pkg.sv
link_speed_pkg.sv
mac_cfg_regs.sv
gmii_tx_framer.sv
gmii_rx_parser.sv
link_speed_detect.sv
rgmii_mac.sv
tb_rgmii_mac.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_rgmii_mac \
    -f rgmii_mac.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== tb_rgmii_mac.sv ====
// Loopback testbench with GMII bytes looped inside the bench and gmii_rx_er held low throughout
`timescale 1ns/1ps
`include "mac_config.svh"

module tb_rgmii_mac;
    import eth_frame_pkg::*;
    import link_speed_pkg::*;

    logic        gtx_clk;
    logic        gtx_rst;
    logic        rgmii_rx_clk;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] cfg_rdata;
    logic [7:0]  s_tx_data;
    logic        s_tx_valid;
    logic        s_tx_last;
    logic        s_tx_ready;
    logic [7:0]  gmii_txd;
    logic        gmii_tx_en;
    logic [7:0]  gmii_rxd;
    logic        gmii_rx_dv;
    logic        gmii_rx_er;
    logic [7:0]  m_rx_data;
    logic        m_rx_valid;
    logic        m_rx_last;
    logic        m_rx_user;
    link_speed_t link_speed;

    logic [31:0] lcg_state = 32'h95eb;
    realtime     rx_half = 4.0;
    int          flip_idx = -1;   // GMII byte index to invert, -1 for none
    int          tx_pos;
    int          ifg_cur = 12;
    int          max_cur = 1518;
    logic [7:0]  exp_tx[$];
    int          exp_tx_len[$];
    logic [7:0]  exp_rx[$];
    int          exp_rx_len[$];
    logic        exp_user[$];
    bit          tx_active;
    int          tx_cnt;
    int          gap;
    int          frames_seen;
    int          rx_cnt;

    rgmii_mac i_dut (.*);

    assign gmii_rxd   = gmii_txd ^ ((tx_pos == flip_idx) ? 8'hff : 8'h00);
    assign gmii_rx_dv = gmii_tx_en;

    initial begin
        gtx_clk = 1'b0;
        forever #2 gtx_clk = ~gtx_clk;
    end

    initial begin
        rgmii_rx_clk = 1'b0;
        forever #(rx_half) rgmii_rx_clk = ~rgmii_rx_clk;
    end

    always @(posedge gtx_clk) begin
        tx_pos <= gmii_tx_en ? tx_pos + 1 : 0;   // Index of the byte now on gmii_txd
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};
    endfunction

    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic timeout(input string what);
        $display("Timeout: %s", what);
        stop_on_failure();
    endtask

    // GMII transmit monitor against the framing model
    always @(negedge gtx_clk) begin
        if (!gtx_rst) begin
            if (gmii_tx_en) begin
                if (!tx_active) begin
                    if (frames_seen > 0) check("ifg gap at least programmed", 1, gap >= ifg_cur);
                    tx_active = 1'b1;
                    tx_cnt = 0;
                end
                if (exp_tx.size() == 0) begin
                    $display("GMII transmitted a byte while no frame was queued");
                    stop_on_failure();
                end
                check("gmii_txd", exp_tx.pop_front(), gmii_txd);
                tx_cnt++;
            end else begin
                if (tx_active) begin
                    check("tx_en length", exp_tx_len.pop_front(), tx_cnt);
                    tx_active = 1'b0;
                    frames_seen++;
                    gap = 0;
                end
                gap++;
            end
        end
    end

    // Receive stream monitor
    always @(negedge gtx_clk) begin
        if (!gtx_rst && m_rx_valid) begin
            if (exp_rx.size() == 0) begin
                $display("Receive stream delivered a byte that no frame expected");
                stop_on_failure();
            end
            check("m_rx_data", exp_rx.pop_front(), m_rx_data);
            rx_cnt++;
            if (m_rx_last) begin
                check("rx frame length", exp_rx_len.pop_front(), rx_cnt);
                check("m_rx_user", exp_user.pop_front(), m_rx_user);
                rx_cnt = 0;
            end
        end
    end

    task automatic cfg_write(input logic [1:0] a, input logic [15:0] d);
        @(negedge gtx_clk);
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge gtx_clk);
        cfg_wr = 1'b0;
    endtask

    task automatic cfg_read_check(input string name, input logic [1:0] a, input logic [15:0] exp);
        @(negedge gtx_clk);
        cfg_addr = a;
        #1;
        check(name, exp, cfg_rdata);
    endtask

    task automatic send_frame(input int n, input bit corrupt, input bit expect_rx);
        logic [7:0]  pl[$];
        logic [31:0] crc;
        logic [31:0] r;
        int          plen;
        int          fidx;
        int          i;
        int          wait_cnt;
        plen = (n < 60) ? 60 : n;
        for (i = 0; i < plen; i++) begin
            r = next_rand();
            pl.push_back((i < n) ? r[7:0] : 8'h00);   // Zero padding
        end
        r = next_rand();
        fidx = corrupt ? 8 + int'(r % n) : -1;
        for (i = 0; i < 7; i++) exp_tx.push_back(8'h55);
        exp_tx.push_back(8'hd5);
        crc = 32'hffffffff;
        for (i = 0; i < plen; i++) begin
            exp_tx.push_back(pl[i]);
            crc = crc32_byte(crc, pl[i]);
        end
        crc = ~crc;
        for (i = 0; i < 4; i++) exp_tx.push_back(crc[8*i +: 8]);   // LSB first
        exp_tx_len.push_back(8 + plen + 4);
        if (expect_rx) begin
            for (i = 0; i < plen; i++) exp_rx.push_back((i == fidx - 8) ? ~pl[i] : pl[i]);
            exp_rx_len.push_back(plen);
            exp_user.push_back(corrupt || (plen + 4 > max_cur));
        end
        flip_idx = fidx;
        @(negedge gtx_clk);
        s_tx_valid = 1'b1;
        s_tx_data  = pl[0];
        s_tx_last  = (n == 1);
        i = 0;
        wait_cnt = 0;
        while (i < n) begin
            if (s_tx_ready) begin
                i++;
                wait_cnt = 0;
                @(negedge gtx_clk);
                if (i < n) begin
                    s_tx_data = pl[i];
                    s_tx_last = (i == n - 1);
                end else begin
                    s_tx_valid = 1'b0;
                    s_tx_last  = 1'b0;
                end
            end else begin
                wait_cnt++;
                if (wait_cnt > 5000) timeout("transmit stream stopped accepting bytes");
                @(negedge gtx_clk);
            end
        end
    endtask

    task automatic drain();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_tx.size() != 0 || exp_tx_len.size() != 0 || exp_rx_len.size() != 0) begin
            wait_cnt++;
            if (wait_cnt > 10000) timeout("queued frames were not all sent and received");
            @(negedge gtx_clk);
        end
        repeat (10) @(negedge gtx_clk);
    endtask

    task automatic settle_speed(input link_speed_t exp, input string name);
        int wait_cnt;
        wait_cnt = 0;
        while (link_speed != exp) begin
            wait_cnt++;
            if (wait_cnt > 20000) timeout("link_speed never reached the expected rate");
            @(negedge gtx_clk);
        end
        repeat (600) begin
            @(negedge gtx_clk);
            check(name, exp, link_speed);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [1:0]  a;
        gtx_rst    = 1'b1;
        cfg_wr     = 1'b0;
        cfg_addr   = 2'd0;
        cfg_wdata  = 16'd0;
        s_tx_data  = 8'd0;
        s_tx_valid = 1'b0;
        s_tx_last  = 1'b0;
        gmii_rx_er = 1'b0;
        repeat (5) @(posedge gtx_clk);
        @(negedge gtx_clk);
        gtx_rst = 1'b0;

        check("tx_en after reset", 0, gmii_tx_en);
        check("tx_ready after reset", 0, s_tx_ready);
        check("rx_valid after reset", 0, m_rx_valid);
        check("link_speed after reset", speed_1000m, link_speed);

        cfg_read_check("ctrl default", `MAC_REG_CTRL, 16'd3);
        cfg_read_check("ifg default", `MAC_REG_IFG, 16'd12);
        cfg_read_check("max_len default", `MAC_REG_MAX_LEN, 16'd1518);
        repeat (10) begin
            r = next_rand();
            a = 2'(r % 3);
            d = next_rand();
            cfg_write(a, d[15:0]);
            if (a == `MAC_REG_CTRL) cfg_read_check("ctrl write", a, {14'd0, d[1:0]});
            else if (a == `MAC_REG_IFG) cfg_read_check("ifg write", a, {8'd0, d[7:0]});
            else cfg_read_check("max_len write", a, d[15:0]);
        end
        r = next_rand();
        ifg_cur = 4 + int'(r % 20);
        cfg_write(`MAC_REG_IFG, 16'(ifg_cur));
        cfg_write(`MAC_REG_MAX_LEN, 16'd1518);
        cfg_write(`MAC_REG_CTRL, 16'd3);

        repeat (20) begin   // Back to back, gaps set by the framer
            r = next_rand();
            send_frame(1 + int'(r % 100), 1'b0, 1'b1);
        end
        drain();

        repeat (10) begin
            r = next_rand();
            d = next_rand();
            send_frame(1 + int'(r % 100), d[0], 1'b1);
            drain();
        end
        send_frame(64, 1'b1, 1'b1);   // At least one corrupted frame
        drain();

        max_cur = 70;
        cfg_write(`MAC_REG_MAX_LEN, 16'd70);
        send_frame(80, 1'b0, 1'b1);
        drain();
        max_cur = 1518;
        cfg_write(`MAC_REG_MAX_LEN, 16'd1518);

        cfg_write(`MAC_REG_CTRL, 16'd2);
        @(negedge gtx_clk);
        s_tx_valid = 1'b1;
        repeat (200) begin
            @(negedge gtx_clk);
            check("tx_en with transmit disabled", 0, gmii_tx_en);
            check("tx_ready with transmit disabled", 0, s_tx_ready);
        end
        s_tx_valid = 1'b0;
        cfg_write(`MAC_REG_CTRL, 16'd1);
        send_frame(30, 1'b0, 1'b0);   // Monitor flags any received byte
        drain();
        cfg_write(`MAC_REG_CTRL, 16'd3);

        settle_speed(speed_1000m, "speed at 8 ns");
        rx_half = 20.0;
        settle_speed(speed_100m, "speed at 40 ns");
        rx_half = 200.0;
        settle_speed(speed_10m, "speed at 400 ns");

        $display("test passed");
        $finish;
    end

endmodule

// ==== rgmii_mac.sv ====
// Single gtx_clk domain MAC with byte-wide GMII ports and no DDR pad logic
`timescale 1ns/1ps
`include "mac_config.svh"

module rgmii_mac (
    input  logic                        gtx_clk,
    input  logic                        gtx_rst,
    input  logic                        rgmii_rx_clk,
    input  logic                        cfg_wr,
    input  logic [`MAC_CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [15:0]                 cfg_wdata,
    output logic [15:0]                 cfg_rdata,
    input  logic [7:0]                  s_tx_data,
    input  logic                        s_tx_valid,
    input  logic                        s_tx_last,
    output logic                        s_tx_ready,
    output logic [7:0]                  gmii_txd,
    output logic                        gmii_tx_en,
    input  logic [7:0]                  gmii_rxd,
    input  logic                        gmii_rx_dv,
    input  logic                        gmii_rx_er,
    output logic [7:0]                  m_rx_data,
    output logic                        m_rx_valid,
    output logic                        m_rx_last,
    output logic                        m_rx_user,
    output link_speed_pkg::link_speed_t link_speed
);

    logic        tx_enable;
    logic        rx_enable;
    logic [7:0]  ifg_len;
    logic [15:0] max_len;   // Oversize limit for the parser

    mac_cfg_regs i_cfg (
        .gtx_clk   (gtx_clk),
        .gtx_rst   (gtx_rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .tx_enable (tx_enable),
        .rx_enable (rx_enable),
        .ifg_len   (ifg_len),
        .max_len   (max_len)
    );

    gmii_tx_framer i_tx (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .tx_enable  (tx_enable),
        .ifg_len    (ifg_len),
        .s_tx_data  (s_tx_data),
        .s_tx_valid (s_tx_valid),
        .s_tx_last  (s_tx_last),
        .s_tx_ready (s_tx_ready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    gmii_rx_parser i_rx (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .rx_enable  (rx_enable),
        .max_len    (max_len),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .m_rx_data  (m_rx_data),
        .m_rx_valid (m_rx_valid),
        .m_rx_last  (m_rx_last),
        .m_rx_user  (m_rx_user)
    );

    link_speed_detect i_speed (
        .gtx_clk      (gtx_clk),
        .gtx_rst      (gtx_rst),
        .rgmii_rx_clk (rgmii_rx_clk),
        .link_speed   (link_speed)
    );

endmodule

// ==== link_speed_detect.sv ====
// The prescaler runs unreset on rgmii_rx_clk and a stopped receive clock reads as 10M
`timescale 1ns/1ps

module link_speed_detect (
    input  logic                        gtx_clk,
    input  logic                        gtx_rst,
    input  logic                        rgmii_rx_clk,
    output link_speed_pkg::link_speed_t link_speed
);
    import link_speed_pkg::*;

    logic [2:0]              rx_prescale = 3'd0;
    logic [1:0]              prescale_sync;
    logic                    prescale_last;
    logic [ref_count_w-1:0]  ref_cnt;
    logic [edge_count_w-1:0] edge_cnt;

    always_ff @(posedge rgmii_rx_clk) begin
        rx_prescale <= rx_prescale + 3'd1;
    end

    always_ff @(posedge gtx_clk) begin
        prescale_sync <= {prescale_sync[0], rx_prescale[2]};
        prescale_last <= prescale_sync[1];

        if (&edge_cnt) begin
            ref_cnt  <= '0;
            edge_cnt <= '0;
            if (ref_cnt[ref_count_w-1 -: 2] != 2'd0) begin
                link_speed <= speed_100m;
            end else begin
                link_speed <= speed_1000m;
            end
        end else if (&ref_cnt) begin
            ref_cnt    <= '0;   // Too few receive edges in the window
            edge_cnt   <= '0;
            link_speed <= speed_10m;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
            if (prescale_sync[1] ^ prescale_last) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
        end

        if (gtx_rst) begin
            prescale_sync <= 2'b00;
            prescale_last <= 1'b0;
            ref_cnt       <= '0;
            edge_cnt      <= '0;
            link_speed    <= speed_1000m;
        end
    end

endmodule

// ==== gmii_rx_parser.sv ====
// Payload leaves 6 cycles after its GMII byte and frames of 4 bytes or fewer after the SFD vanish
`timescale 1ns/1ps

module gmii_rx_parser (
    input  logic        gtx_clk,
    input  logic        gtx_rst,
    input  logic        rx_enable,
    input  logic [15:0] max_len,
    input  logic [7:0]  gmii_rxd,
    input  logic        gmii_rx_dv,
    input  logic        gmii_rx_er,
    output logic [7:0]  m_rx_data,
    output logic        m_rx_valid,
    output logic        m_rx_last,
    output logic        m_rx_user
);
    import eth_frame_pkg::*;

    // FCS holdback plus the byte waiting to learn whether it is last
    localparam int hold_depth = 5;
    localparam logic [15:0] min_frame_len = 16'(min_payload_len) + 16'(fcs_len);

    logic                  in_frame;
    logic                  discard;   // Bad preamble or receive disabled
    logic [7:0]            dly [hold_depth];
    logic [hold_depth-1:0] dly_vld;
    logic [31:0]           crc;
    logic [15:0]           len;
    logic                  err;
    logic                  frame_bad;

    assign frame_bad = (crc != crc_residue) || err || (len > max_len) || (len < min_frame_len);

    always_ff @(posedge gtx_clk) begin
        m_rx_valid <= 1'b0;
        m_rx_last  <= 1'b0;
        m_rx_user  <= 1'b0;

        if (gmii_rx_dv) begin
            if (in_frame) begin
                dly[0] <= gmii_rxd;
                for (int i = 1; i < hold_depth; i++) begin
                    dly[i] <= dly[i-1];
                end
                dly_vld <= {dly_vld[hold_depth-2:0], 1'b1};
                crc     <= crc32_byte(crc, gmii_rxd);
                if (~&len) begin
                    len <= len + 16'd1;
                end
                if (gmii_rx_er) begin
                    err <= 1'b1;
                end
                if (dly_vld[hold_depth-1]) begin
                    m_rx_data  <= dly[hold_depth-1];
                    m_rx_valid <= 1'b1;
                end
            end else if (!discard) begin
                if (gmii_rxd == sfd_byte) begin
                    in_frame <= rx_enable;
                    discard  <= !rx_enable;
                    crc      <= 32'hffffffff;
                    len      <= 16'd0;
                    err      <= gmii_rx_er;
                end else if (gmii_rxd != preamble_byte) begin
                    discard <= 1'b1;
                end
            end
        end else begin
            in_frame <= 1'b0;
            discard  <= 1'b0;
            dly_vld  <= '0;
            if (in_frame && dly_vld[hold_depth-1]) begin
                m_rx_data  <= dly[hold_depth-1];   // Remaining four bytes are the FCS
                m_rx_valid <= 1'b1;
                m_rx_last  <= 1'b1;
                m_rx_user  <= frame_bad;
            end
        end

        if (gtx_rst) begin
            in_frame   <= 1'b0;
            discard    <= 1'b0;
            dly_vld    <= '0;
            err        <= 1'b0;
            m_rx_valid <= 1'b0;
            m_rx_last  <= 1'b0;
            m_rx_user  <= 1'b0;
        end
    end

    a_last_with_valid: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        m_rx_last |-> m_rx_valid)
        else $error("m_rx_last without m_rx_valid");

endmodule

// ==== gmii_tx_framer.sv ====
// The source must keep s_tx_valid high from first to last byte since underflow is not handled
`timescale 1ns/1ps

module gmii_tx_framer (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic       tx_enable,
    input  logic [7:0] ifg_len,
    input  logic [7:0] s_tx_data,
    input  logic       s_tx_valid,
    input  logic       s_tx_last,
    output logic       s_tx_ready,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en
);
    import eth_frame_pkg::*;

    tx_state_t   state;
    logic [7:0]  cnt;   // Preamble, payload, FCS or IFG position
    logic [31:0] crc;

    assign s_tx_ready = (state == tx_data);

    always_ff @(posedge gtx_clk) begin
        case (state)
            tx_idle: begin
                gmii_txd   <= 8'h00;
                gmii_tx_en <= 1'b0;
                if (tx_enable && s_tx_valid) begin
                    state      <= tx_preamble;
                    gmii_txd   <= preamble_byte;
                    gmii_tx_en <= 1'b1;
                    cnt        <= 8'd1;
                    crc        <= 32'hffffffff;
                end
            end

            tx_preamble: begin
                if (cnt == preamble_len) begin
                    gmii_txd <= sfd_byte;
                    state    <= tx_data;
                    cnt      <= 8'd0;
                end else begin
                    gmii_txd <= preamble_byte;
                    cnt      <= cnt + 8'd1;
                end
            end

            tx_data: begin
                if (s_tx_valid) begin
                    gmii_txd <= s_tx_data;
                    crc      <= crc32_byte(crc, s_tx_data);
                    if (cnt < min_payload_len) begin
                        cnt <= cnt + 8'd1;   // Saturates once no padding is needed
                    end
                    if (s_tx_last) begin
                        if (cnt + 8'd1 >= min_payload_len) begin
                            state <= tx_fcs;
                            cnt   <= 8'd0;
                        end else begin
                            state <= tx_pad;
                        end
                    end
                end
            end

            tx_pad: begin
                gmii_txd <= 8'h00;
                crc      <= crc32_byte(crc, 8'h00);
                if (cnt == min_payload_len - 8'd1) begin
                    state <= tx_fcs;
                    cnt   <= 8'd0;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end

            tx_fcs: begin
                gmii_txd <= ~crc[7:0];
                crc      <= {8'hff, crc[31:8]};
                if (cnt == fcs_len - 8'd1) begin
                    state <= tx_ifg;
                    cnt   <= 8'd1;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end

            tx_ifg: begin
                gmii_txd   <= 8'h00;
                gmii_tx_en <= 1'b0;
                if (cnt >= ifg_len) begin
                    state <= tx_idle;   // Start check adds one more idle cycle
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end

            default: state <= tx_idle;
        endcase

        if (gtx_rst) begin
            state      <= tx_idle;
            cnt        <= 8'd0;
            gmii_tx_en <= 1'b0;
        end
    end

    a_no_underflow: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        s_tx_valid && s_tx_ready && !s_tx_last |=> s_tx_valid)
        else $error("Transmit source dropped valid inside a frame");

    a_ifg_quiet: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        state == tx_ifg && cnt < ifg_len |=> state == tx_ifg && !gmii_tx_en)
        else $error("Inter-frame gap cut short or gmii_tx_en high inside it");

endmodule

// ==== mac_cfg_regs.sv ====
// Writes land on the gtx_clk edge with cfg_wr high and the unmapped address reads as zero
`timescale 1ns/1ps
`include "mac_config.svh"

module mac_cfg_regs (
    input  logic                       gtx_clk,
    input  logic                       gtx_rst,
    input  logic                       cfg_wr,
    input  logic [`MAC_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [15:0]                cfg_wdata,
    output logic [15:0]                cfg_rdata,
    output logic                       tx_enable,
    output logic                       rx_enable,
    output logic [7:0]                 ifg_len,
    output logic [15:0]                max_len
);

    always_ff @(posedge gtx_clk) begin
        if (cfg_wr) begin
            case (cfg_addr)
                `MAC_REG_CTRL: begin
                    tx_enable <= cfg_wdata[0];
                    rx_enable <= cfg_wdata[1];
                end
                `MAC_REG_IFG: ifg_len <= cfg_wdata[7:0];   // Upper byte ignored
                `MAC_REG_MAX_LEN: max_len <= cfg_wdata;
                default: ;
            endcase
        end

        if (gtx_rst) begin
            tx_enable <= 1'b1;
            rx_enable <= 1'b1;
            ifg_len   <= `MAC_DEFAULT_IFG;
            max_len   <= `MAC_DEFAULT_MAX_LEN;
        end
    end

    always_comb begin
        case (cfg_addr)
            `MAC_REG_CTRL: cfg_rdata = {14'd0, rx_enable, tx_enable};
            `MAC_REG_IFG: cfg_rdata = {8'd0, ifg_len};
            `MAC_REG_MAX_LEN: cfg_rdata = max_len;
            default: cfg_rdata = 16'h0000;
        endcase
    end

    a_cfg_addr_mapped: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        cfg_wr |-> cfg_addr <= `MAC_REG_MAX_LEN)
        else $error("Configuration write to unmapped address %0d", cfg_addr);

endmodule

// ==== link_speed_pkg.sv ====
// Counter widths set the detector windows in gtx_clk cycles and must track its frequency
package link_speed_pkg;

    typedef enum logic [1:0] {
        speed_10m   = 2'd0,
        speed_100m  = 2'd1,
        speed_1000m = 2'd2
    } link_speed_t;

    // Reference counter saturating first means 10M
    localparam int ref_count_w = 7;

    // Prescaled receive clock toggles counted per window
    localparam int edge_count_w = 2;

endpackage

// ==== eth_frame_pkg.sv ====
// Framing constants and CRC-32 for an 8-bit datapath, with the FCS sent and checked LSB first
package eth_frame_pkg;

    localparam logic [7:0]  preamble_byte   = 8'h55;
    localparam logic [7:0]  sfd_byte        = 8'hd5;
    localparam logic [7:0]  preamble_len    = 8'd7;
    localparam logic [7:0]  min_payload_len = 8'd60;   // Padded length before FCS
    localparam logic [7:0]  fcs_len         = 8'd4;
    localparam logic [31:0] crc_residue     = 32'hdebb20e3;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_data,
        tx_pad,
        tx_fcs,
        tx_ifg
    } tx_state_t;

    // Reflected CRC-32, one bit per iteration
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// ==== mac_config.svh ====
// Reset defaults and register map of the MAC register block, addresses are 2-bit word indices
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

`define MAC_DEFAULT_IFG 8'd12

// Payload plus FCS, preamble not counted
`define MAC_DEFAULT_MAX_LEN 16'd1518

`define MAC_CFG_ADDR_W 2

// Bit 0 transmit enable, bit 1 receive enable
`define MAC_REG_CTRL 2'd0
`define MAC_REG_IFG 2'd1
`define MAC_REG_MAX_LEN 2'd2

`endif
